// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath widths
`define CPU_DATA_W 16
`define CPU_BYTE_W 8
`define CPU_ADDR_W 16

// three bytes, opcode in the low byte
`define CPU_INST_W 24

// first fetch after reset
`define CPU_RESET_PC 16'h4000

// instruction lengths in bytes
`define CPU_ILEN_OP 1
`define CPU_ILEN_IMM8 2
`define CPU_ILEN_IMM16 3

`endif

// File: cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_BYTE_W-1:0] byte_t;
	typedef logic [`CPU_INST_W-1:0] inst_t;

	// bit 1 enables the high byte
	typedef logic [1:0] byte_en_t;

	// n z c, c in bit 0
	typedef logic [2:0] flags_t;

	typedef enum logic [7:0] {
		NOP         = 8'h00,
		LD_XL_IMMD  = 8'h10,
		ADD_XL_IMMD = 8'h11,
		SUB_XL_IMMD = 8'h12,
		AND_XL_IMMD = 8'h13,
		OR_XL_IMMD  = 8'h14,
		XOR_XL_IMMD = 8'h15,
		INC_XL      = 8'h16,
		LDW_Y_IMMD  = 8'h20,
		INCW_Y      = 8'h21,
		LD_XL_DIR   = 8'h30,
		LD_DIR_XL   = 8'h31,
		LDW_DIR_Y   = 8'h32,
		JP_IMMD     = 8'h40,
		JR_D        = 8'h41,
		JRZ_D       = 8'h42,
		JRNZ_D      = 8'h43,
		JRC_D       = 8'h44,
		TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		PASS,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		INC,
		PASSW,
		INCW
	} alu_op_t;

	typedef enum logic [0:0] {
		REG_X,
		REG_Y
	} reg_sel_t;

endpackage

// File: regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regfile
	import cpu_pkg::*;
(
	input logic clk,
	input reg_sel_t reg_sel,
	input word_t reg_wdata,
	input byte_en_t reg_wen,
	output word_t x,
	output word_t y
);
	word_t regs [2];

	assign x = regs[REG_X];
	assign y = regs[REG_Y];

	always_ff @(posedge clk)
	begin
		if (reg_wen[0])
			regs[reg_sel][`CPU_BYTE_W-1:0] <= reg_wdata[`CPU_BYTE_W-1:0];
		if (reg_wen[1])
			regs[reg_sel][`CPU_DATA_W-1:`CPU_BYTE_W] <= reg_wdata[`CPU_DATA_W-1:`CPU_BYTE_W];
	end

	// decoder enables stay defined on every edge
	assert property (@(posedge clk) !$isunknown(reg_wen))
	else
		$error("regfile write enable went unknown");

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu
	import cpu_pkg::*;
(
	input alu_op_t alu_op,
	input word_t op_a,
	input word_t op_b,
	output word_t result,
	output logic c_out,
	output logic z_out,
	output logic n_out
);
	byte_t a8;
	byte_t b8;
	byte_t res8;
	word_t res16;
	logic carry;
	logic wide;

	assign a8 = op_a[`CPU_BYTE_W-1:0];
	assign b8 = op_b[`CPU_BYTE_W-1:0];

	always_comb
	begin
		wide = 1'b0;
		carry = 1'b0;
		res8 = a8;
		res16 = op_a;
		case (alu_op)
			ADD: {carry, res8} = {1'b0, a8} + {1'b0, b8};
			// a leading one makes carry read as "no borrow"
			SUB: {carry, res8} = {1'b1, a8} - {1'b0, b8};
			AND: res8 = a8 & b8;
			OR: res8 = a8 | b8;
			XOR: res8 = a8 ^ b8;
			INC: {carry, res8} = {1'b0, a8} + 1'b1;
			PASSW: wide = 1'b1;
			INCW:
			begin
				wide = 1'b1;
				{carry, res16} = {1'b0, op_a} + 1'b1;
			end
			default: res8 = a8;
		endcase
	end

	// 8-bit ops keep the high byte of op_a
	assign result = wide ? res16 : {op_a[`CPU_DATA_W-1:`CPU_BYTE_W], res8};
	assign c_out = carry;
	assign z_out = wide ? (res16 == '0) : (res8 == '0);
	assign n_out = wide ? res16[`CPU_DATA_W-1] : res8[`CPU_BYTE_W-1];

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input inst_t iread_data,
	input flags_t next_flags,
	output word_t iread_addr,
	output word_t dread_addr,
	output inst_t inst
);
	word_t pc;
	word_t next_pc;
	word_t operand;
	word_t rel_target;
	word_t ilen;
	opcode_t fetch_op;
	logic taken;

	assign fetch_op = opcode_t'(iread_data[7:0]);
	assign operand = iread_data[`CPU_INST_W-1:8];

	// displacement is relative to the jr itself
	assign rel_target = pc + {{(`CPU_ADDR_W-`CPU_BYTE_W){iread_data[15]}}, iread_data[15:8]};

	// flags come from the instruction now executing
	always_comb
	begin
		case (fetch_op)
			JR_D: taken = 1'b1;
			JRZ_D: taken = next_flags[1];
			JRNZ_D: taken = !next_flags[1];
			JRC_D: taken = next_flags[0];
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		case (fetch_op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			JR_D, JRZ_D, JRNZ_D, JRC_D:
				ilen = `CPU_ILEN_IMM8;
			LDW_Y_IMMD, LD_XL_DIR, LD_DIR_XL, LDW_DIR_Y, JP_IMMD:
				ilen = `CPU_ILEN_IMM16;
			default:
				ilen = `CPU_ILEN_OP;
		endcase

		if (fetch_op == JP_IMMD)
			next_pc = operand;
		else if (taken)
			next_pc = rel_target;
		else
			next_pc = pc + ilen;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `CPU_RESET_PC;
			inst <= inst_t'(NOP);
		end
		else
		begin
			pc <= next_pc;
			inst <= iread_data;
		end
	end

	assign iread_addr = pc;
	// synchronous data memory answers while the load executes
	assign dread_addr = (fetch_op == LD_XL_DIR) ? operand : '0;

	assert property (@(posedge clk) reset |=> iread_addr == `CPU_RESET_PC)
	else
		$error("fetch did not restart at the reset vector");

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module exec_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input inst_t inst,
	input word_t x,
	input word_t y,
	input word_t dread_data,
	input word_t result,
	input logic c_out,
	input logic z_out,
	input logic n_out,
	output alu_op_t alu_op,
	output word_t op_a,
	output word_t op_b,
	output reg_sel_t reg_sel,
	output word_t reg_wdata,
	output byte_en_t reg_wen,
	output flags_t next_flags,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en,
	output logic trap
);
	opcode_t opcode;
	word_t imm8;
	word_t imm16;
	flags_t flags;
	logic upd_flags;

	assign opcode = opcode_t'(inst[7:0]);
	assign imm8 = {{(`CPU_DATA_W-`CPU_BYTE_W){1'b0}}, inst[15:8]};
	assign imm16 = inst[`CPU_INST_W-1:8];

	always_comb
	begin
		alu_op = PASS;
		op_a = x;
		op_b = imm8;
		reg_sel = REG_X;
		reg_wen = 2'b00;
		dwrite_en = 2'b00;
		upd_flags = 1'b0;
		case (opcode)
			LD_XL_IMMD:
			begin
				op_a = imm8;
				reg_wen = 2'b01;
			end
			ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
			begin
				case (opcode)
					ADD_XL_IMMD: alu_op = ADD;
					SUB_XL_IMMD: alu_op = SUB;
					AND_XL_IMMD: alu_op = AND;
					OR_XL_IMMD: alu_op = OR;
					default: alu_op = XOR;
				endcase
				reg_wen = 2'b01;
				upd_flags = 1'b1;
			end
			INC_XL:
			begin
				alu_op = INC;
				reg_wen = 2'b01;
				upd_flags = 1'b1;
			end
			LDW_Y_IMMD:
			begin
				alu_op = PASSW;
				op_a = imm16;
				reg_sel = REG_Y;
				reg_wen = 2'b11;
			end
			INCW_Y:
			begin
				alu_op = INCW;
				op_a = y;
				reg_sel = REG_Y;
				reg_wen = 2'b11;
				upd_flags = 1'b1;
			end
			LD_XL_DIR:
			begin
				// read was issued while this word was fetched
				op_a = dread_data;
				reg_wen = 2'b01;
			end
			LD_DIR_XL:
				dwrite_en = 2'b01;
			LDW_DIR_Y:
			begin
				alu_op = PASSW;
				op_a = y;
				dwrite_en = 2'b11;
			end
			default:
			begin
				// nop, jumps, trap and unknown opcodes change nothing here
			end
		endcase

		// no stores while reset is high
		if (reset)
			dwrite_en = 2'b00;
	end

	assign reg_wdata = result;
	assign dwrite_addr = imm16;
	assign dwrite_data = result;
	assign trap = !reset && (opcode == TRAP);

	// fetch decides branches on these before the edge
	assign next_flags = upd_flags ? {n_out, z_out, c_out} : flags;

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	// inst is forced to nop by fetch during reset
	assert property (@(posedge clk) reset |=> dwrite_en == 2'b00)
	else
		$error("data write enabled during reset");

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	output word_t iread_addr,
	input inst_t iread_data,
	output word_t dread_addr,
	input word_t dread_data,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output byte_en_t dwrite_en,
	output logic trap
);
	inst_t inst;
	flags_t next_flags;
	word_t x;
	word_t y;
	reg_sel_t reg_sel;
	word_t reg_wdata;
	byte_en_t reg_wen;
	alu_op_t alu_op;
	word_t op_a;
	word_t op_b;
	word_t result;
	logic c_out;
	logic z_out;
	logic n_out;

	fetch_unit fetch_i (
		.clk(clk), .reset(reset), .iread_data(iread_data), .next_flags(next_flags),
		.iread_addr(iread_addr), .dread_addr(dread_addr), .inst(inst)
	);

	exec_unit exec_i (
		.clk(clk), .reset(reset), .inst(inst), .x(x), .y(y), .dread_data(dread_data),
		.result(result), .c_out(c_out), .z_out(z_out), .n_out(n_out),
		.alu_op(alu_op), .op_a(op_a), .op_b(op_b),
		.reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_wen(reg_wen), .next_flags(next_flags),
		.dwrite_addr(dwrite_addr), .dwrite_data(dwrite_data), .dwrite_en(dwrite_en),
		.trap(trap)
	);

	regfile regs_i (
		.clk(clk), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_wen(reg_wen), .x(x), .y(y)
	);

	alu alu_i (
		.alu_op(alu_op), .op_a(op_a), .op_b(op_b),
		.result(result), .c_out(c_out), .z_out(z_out), .n_out(n_out)
	);

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu
	import cpu_pkg::*;
();
	logic clk;
	logic reset;
	word_t iread_addr;
	inst_t iread_data;
	word_t dread_addr;
	word_t dread_data = '0;
	word_t dwrite_addr;
	word_t dwrite_data;
	byte_en_t dwrite_en;
	logic trap;

	byte_t imem [0:65535];
	byte_t dmem [0:65535];
	word_t wr_data [$];
	byte_en_t wr_en [$];
	word_t ptr;
	byte_t cur_op;
	integer seed;

	// opcode, a, b, preset byte at 0200, expected 0100, expected 0101
	logic [47:0] program_table [14] = '{
		{ADD_XL_IMMD, 8'h12, 8'h34, 8'h00, 8'h46, 8'h46},
		{ADD_XL_IMMD, 8'hf0, 8'h20, 8'h00, 8'h10, 8'h5a},
		{SUB_XL_IMMD, 8'h50, 8'h20, 8'h00, 8'h30, 8'h5a},
		{SUB_XL_IMMD, 8'h20, 8'h50, 8'h00, 8'hd0, 8'hd0},
		{AND_XL_IMMD, 8'hf0, 8'h3c, 8'h00, 8'h30, 8'h30},
		{OR_XL_IMMD, 8'h0f, 8'h30, 8'h00, 8'h3f, 8'h3f},
		{XOR_XL_IMMD, 8'hff, 8'h0f, 8'h00, 8'hf0, 8'hf0},
		{INC_XL, 8'h7f, 8'h00, 8'h00, 8'h80, 8'h80},
		{INC_XL, 8'hff, 8'h00, 8'h00, 8'h00, 8'h5a},
		{LDW_Y_IMMD, 8'hff, 8'h12, 8'h00, 8'h00, 8'h13},
		{LD_XL_DIR, 8'h00, 8'h05, 8'h40, 8'h45, 8'h5a},
		{LD_XL_DIR, 8'h00, 8'h20, 8'hf0, 8'h10, 8'h5a},
		{JRNZ_D, 8'h00, 8'h00, 8'h00, 8'h00, 8'h5a},
		{JP_IMMD, 8'h5c, 8'h00, 8'h00, 8'h00, 8'h5a}
	};

	byte_t random_ops [9] = '{ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD,
		XOR_XL_IMMD, INC_XL, LDW_Y_IMMD, LD_XL_DIR, JP_IMMD};

	cpu cpu_i (
		.clk(clk), .reset(reset), .iread_addr(iread_addr), .iread_data(iread_data),
		.dread_addr(dread_addr), .dread_data(dread_data), .dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data), .dwrite_en(dwrite_en), .trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// code memory answers in the same cycle
	assign iread_data = {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};

	always @(posedge clk)
	begin
		dread_data <= {dmem[dread_addr + 16'd1], dmem[dread_addr]};
		if (dwrite_en != 2'b00)
		begin
			wr_data.push_back(dwrite_data);
			wr_en.push_back(dwrite_en);
		end
		if (dwrite_en[0])
			dmem[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] <= dwrite_data[15:8];
	end

	function automatic byte_t fill_byte(input word_t addr);
		return addr[7:0] ^ addr[15:8] ^ 8'h5a;
	endfunction

	// {c, result} from the instruction rules
	function automatic logic [8:0] model_alu(input byte_t op, input byte_t a, input byte_t b);
		int s;
		logic c;
		c = 1'b0;
		case (op)
			ADD_XL_IMMD:
			begin
				s = int'(a) + int'(b);
				c = s > 255;
			end
			SUB_XL_IMMD:
			begin
				s = int'(a) - int'(b) + 256;
				c = a >= b;
			end
			AND_XL_IMMD: s = int'(a & b);
			OR_XL_IMMD: s = int'(a | b);
			XOR_XL_IMMD: s = int'(a ^ b);
			INC_XL:
			begin
				s = int'(a) + 1;
				c = s > 255;
			end
			default: s = int'(a);
		endcase
		return {c, s[7:0]};
	endfunction

	task automatic check(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0d ns: opcode %h, %s: got %h, expected %h",
				$time, cur_op, what, actual, expected);
			$display("Regression failed");
			$fatal(1, "check failed");
		end
	endtask

	task automatic emit(input byte_t op, input word_t operand, input int len);
		imem[ptr] = op;
		if (len > 1)
			imem[ptr + 16'd1] = operand[7:0];
		if (len > 2)
			imem[ptr + 16'd2] = operand[15:8];
		ptr = ptr + 16'(len);
	endtask

	task automatic run_row(input byte_t op, input byte_t a, input byte_t b, input byte_t pre,
			input byte_t lo, input byte_t hi);
		int cycles;
		cur_op = op;
		@(posedge clk);
		#2;
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
		begin
			imem[i] = TRAP;
			dmem[i] = fill_byte(16'(i));
		end
		wr_data.delete();
		wr_en.delete();
		ptr = `CPU_RESET_PC;
		case (op)
			LDW_Y_IMMD:
			begin
				emit(LDW_Y_IMMD, {b, a}, 3);
				emit(INCW_Y, '0, 1);
				emit(LDW_DIR_Y, 16'h0100, 3);
			end
			LD_XL_DIR:
			begin
				dmem[16'h0200] = pre;
				emit(LD_XL_DIR, 16'h0200, 3);
				emit(ADD_XL_IMMD, {8'h00, b}, 2);
				emit(LD_DIR_XL, 16'h0100, 3);
			end
			JRNZ_D:
			begin
				emit(LD_XL_IMMD, 16'h0003, 2);
				emit(SUB_XL_IMMD, 16'h0001, 2);
				emit(LD_DIR_XL, 16'h0100, 3);
				// back to the sub, five bytes up
				emit(JRNZ_D, 16'h00fb, 2);
			end
			JP_IMMD:
			begin
				emit(JP_IMMD, 16'h4006, 3);
				emit(LD_DIR_XL, 16'h0101, 3);
				emit(LD_XL_IMMD, {8'h00, a}, 2);
				emit(SUB_XL_IMMD, {8'h00, a}, 2);
				emit(LD_DIR_XL, 16'h0100, 3);
				emit(JRZ_D, 16'h0005, 2);
				emit(LD_DIR_XL, 16'h0101, 3);
			end
			default:
			begin
				emit(LD_XL_IMMD, {8'h00, a}, 2);
				emit(op, {8'h00, b}, (op == INC_XL) ? 1 : 2);
				emit(LD_DIR_XL, 16'h0100, 3);
				// skips the second store when c is set
				emit(JRC_D, 16'h0005, 2);
				emit(LD_DIR_XL, 16'h0101, 3);
			end
		endcase
		emit(TRAP, '0, 1);
		// strobes drop as soon as reset rises
		#1;
		check({14'd0, dwrite_en}, 16'h0000, "write enables as reset rises");
		check({15'd0, trap}, 16'h0000, "trap as reset rises");
		repeat (4)
		begin
			@(posedge clk);
			#2;
			check(iread_addr, `CPU_RESET_PC, "fetch address in reset");
			check({14'd0, dwrite_en}, 16'h0000, "write enables in reset");
			check({15'd0, trap}, 16'h0000, "trap in reset");
		end
		reset = 1'b0;
		cycles = 0;
		while (trap !== 1'b1 && cycles < 200)
		begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (trap !== 1'b1)
		begin
			$display("trap never asserted within 200 cycles for opcode %h", op);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
		case (op)
			LDW_Y_IMMD:
			begin
				check(16'(wr_en.size()), 16'd1, "word store count");
				check({14'd0, wr_en[0]}, 16'h0003, "word store enables");
			end
			JRNZ_D:
			begin
				check(16'(wr_en.size()), 16'd3, "countdown store count");
				for (int j = 0; j < 3; j++)
					check({8'h00, wr_data[j][7:0]}, 16'(2 - j), "countdown store value");
			end
			JP_IMMD, LD_XL_DIR:
				check(16'(wr_en.size()), 16'd1, "store count");
			default:
			begin
			end
		endcase
		check({8'h00, dmem[16'h0100]}, {8'h00, lo}, "byte at 0100");
		check({8'h00, dmem[16'h0101]}, {8'h00, hi}, "byte at 0101");
	endtask

	initial
	begin
		byte_t op, a, b, pre, lo, hi;
		logic [8:0] alu_exp;
		word_t w;
		reset = 1'b1;
		seed = 32'heceb9372;
		foreach (program_table[r])
		begin
			{op, a, b, pre, lo, hi} = program_table[r];
			run_row(op, a, b, pre, lo, hi);
		end
		for (int i = 0; i < 27; i++)
		begin
			op = random_ops[i % 9];
			a = 8'($random(seed));
			b = 8'($random(seed));
			pre = 8'($random(seed));
			case (op)
				LDW_Y_IMMD:
				begin
					w = {b, a} + 16'd1;
					lo = w[7:0];
					hi = w[15:8];
				end
				LD_XL_DIR:
				begin
					lo = pre + b;
					hi = fill_byte(16'h0101);
				end
				JP_IMMD:
				begin
					lo = 8'h00;
					hi = fill_byte(16'h0101);
				end
				default:
				begin
					alu_exp = model_alu(op, a, b);
					lo = alu_exp[7:0];
					hi = alu_exp[8] ? fill_byte(16'h0101) : alu_exp[7:0];
				end
			endcase
			run_row(op, a, b, pre, lo, hi);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
cpu_pkg.sv
regfile.sv
alu.sv
fetch_unit.sv
exec_unit.sv
cpu.sv
tb_cpu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_cpu
FILELIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
